/* sfp_link_ctrl_top.f */
design/sfp_link_ctrl_pkg.sv
design/tx_command_scheduler.sv
design/led_status_driver.sv
design/sfp_link_ctrl_top.sv
test/tb_sfp_link_checks.sv
test/tb_sfp_link_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log for the fail message
cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --assert --timescale 1ns/1ps \
    --top-module tb_sfp_link_ctrl -f sfp_link_ctrl_top.f \
    --Mdir obj_dir -o tb_sfp_link_ctrl > "$log_file" 2>&1 &&
    ./obj_dir/tb_sfp_link_ctrl >> "$log_file" 2>&1 ||
    { echo "build or run error, see $log_file"; exit 1; }

grep -q "TESTS FAILED" "$log_file" && { echo "simulation failed, see $log_file"; exit 1; }
grep -q "TESTS PASSED" "$log_file" || { echo "no result in $log_file"; exit 1; }
echo "simulation passed"
exit 0

/* test/tb_sfp_link_ctrl.sv */
// testbench top running reset, indicator, send and link drop sequences on the link control DUT
module tb_sfp_link_ctrl;
    timeunit 1ns;
    timeprecision 1ps;

    import sfp_link_ctrl_pkg::*;

    localparam logic [31:0] random_seed   = 32'hab3b_6cc5;
    localparam int          strobe_period = int'(period_send_2) + int'(wrap_offset) + 1;

    logic                   clk_50_pll;
    logic                   main_reset;
    logic                   mac_inited;
    logic                   rx_ready;
    logic                   rx_locked_to_ref;
    logic                   host_send_cmd;
    logic [host_addr_w-1:0] host_start_addr;
    logic                   data_saved_2;
    logic                   cmd_send_1;
    ram_addr_t              start_ram_addr_1;
    logic                   cmd_send_2;
    ram_addr_t              start_ram_addr_2;
    logic                   blink_led;
    logic                   sfp_txflt_led;
    logic                   sfp_rlos_led;
    logic                   sfp_prsn_led;

    int                     fail_count;        // kept by the checker
    int                     failures_before;   // count when the current test began
    int                     tests_run;
    logic [31:0]            rand_bits;

    sfp_link_ctrl_top UUT (.*);

    tb_sfp_link_checks checks (.*);

    always #4 clk_50_pll = ~clk_50_pll;   // 8 ns period

    task automatic idle_cycles(input int count);
        repeat (count) @(posedge clk_50_pll);
    endtask

    // returns on the edge where the last wanted rise is seen
    task automatic wait_ch1_rises(input int rises, input int limit);
        int   seen;
        int   cycles;
        logic last;
        seen   = 0;
        cycles = 0;
        last   = cmd_send_1;
        while (seen < rises && cycles < limit)
        begin
            @(posedge clk_50_pll);
            if (cmd_send_1 && !last)
            begin
                seen = seen + 1;
            end
            last   = cmd_send_1;
            cycles = cycles + 1;
        end
        if (seen < rises)
        begin
            $display("timeout: cmd_send_1 rose %0d of %0d times in %0d cycles", seen, rises, limit);
            $display("TESTS FAILED");
            $finish;
        end
    endtask

    task automatic close_test(input string name);
        tests_run = tests_run + 1;
        $display("test %0d %s done, %0d check failures", tests_run, name,
                 fail_count - failures_before);
        failures_before = fail_count;
    endtask

    initial
    begin
        clk_50_pll       = 1'b0;
        main_reset       = 1'b1;
        mac_inited       = 1'b0;
        rx_ready         = 1'b0;
        rx_locked_to_ref = 1'b0;
        host_send_cmd    = 1'b0;
        host_start_addr  = '0;
        data_saved_2     = 1'b0;
        tests_run        = 0;
        failures_before  = 0;
        rand_bits        = $urandom(random_seed);   // seeds the whole run

        // ------------------------------------------------------------
        // reset and indicators
        // ------------------------------------------------------------
        repeat (3) @(posedge clk_50_pll);
        main_reset <= 1'b0;
        idle_cycles(4);
        close_test("reset state");

        for (int i = 0; i < 3 * int'(blink_half_period); i++)
        begin
            @(posedge clk_50_pll);
            rand_bits = $urandom;
            mac_inited       <= rand_bits[0];
            rx_ready         <= rand_bits[1];
            rx_locked_to_ref <= rand_bits[2];
            data_saved_2     <= rand_bits[3];
            host_send_cmd    <= rand_bits[4];
        end
        close_test("indicators");

        // ------------------------------------------------------------
        // transmit channels, link held up
        // ------------------------------------------------------------
        rand_bits = $urandom;
        mac_inited       <= 1'b1;
        rx_ready         <= 1'b1;
        rx_locked_to_ref <= 1'b1;
        host_send_cmd    <= 1'b1;
        data_saved_2     <= 1'b0;
        host_start_addr  <= rand_bits[host_addr_w-1:0];
        wait_ch1_rises(3, 4 * strobe_period);
        idle_cycles(6);   // let the last strobe fall
        close_test("channel 1 strobe");

        for (int i = 0; i < strobe_period + 40; i++)
        begin
            @(posedge clk_50_pll);
            rand_bits = $urandom;
            host_start_addr <= rand_bits[host_addr_w-1:0];
        end
        close_test("channel 2 host mode");

        host_send_cmd <= 1'b0;
        for (int i = 0; i < 24; i++)
        begin
            rand_bits = $urandom;
            data_saved_2 <= ~data_saved_2;
            idle_cycles(1 + int'(rand_bits[2:0]));   // random spacing of 1 to 8
        end
        close_test("channel 2 relay mode");

        // ------------------------------------------------------------
        // link drops during a strobe and during a relay
        // ------------------------------------------------------------
        data_saved_2  <= 1'b0;
        host_send_cmd <= 1'b1;
        wait_ch1_rises(1, 2 * strobe_period);
        rx_ready <= 1'b0;   // strobe frozen high
        idle_cycles(12);
        rx_ready <= 1'b1;
        idle_cycles(8);
        host_send_cmd <= 1'b0;
        data_saved_2  <= 1'b1;
        idle_cycles(4);
        mac_inited <= 1'b0;
        idle_cycles(2);
        data_saved_2 <= 1'b0;   // ignored until the link returns
        idle_cycles(10);
        mac_inited <= 1'b1;
        idle_cycles(6);
        close_test("link gate");

        $display("tests run %0d, check failures %0d", tests_run, fail_count);
        if (fail_count == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_sfp_link_ctrl

/* test/tb_sfp_link_checks.sv */
// concurrent port checks for the link control DUT, instantiated beside it in the testbench
module tb_sfp_link_checks
(
    input  logic                                        clk_50_pll,
    input  logic                                        main_reset,
    input  logic                                        mac_inited,
    input  logic                                        rx_ready,
    input  logic                                        rx_locked_to_ref,
    input  logic                                        host_send_cmd,
    input  logic [sfp_link_ctrl_pkg::host_addr_w-1:0]   host_start_addr,
    input  logic                                        data_saved_2,
    input  logic                                        cmd_send_1,
    input  sfp_link_ctrl_pkg::ram_addr_t                start_ram_addr_1,
    input  logic                                        cmd_send_2,
    input  sfp_link_ctrl_pkg::ram_addr_t                start_ram_addr_2,
    input  logic                                        blink_led,
    input  logic                                        sfp_txflt_led,
    input  logic                                        sfp_rlos_led,
    input  logic                                        sfp_prsn_led,
    output int                                          fail_count
);
    timeunit 1ns;
    timeprecision 1ps;

    import sfp_link_ctrl_pkg::*;

    // strobe repeats once per full counter cycle from 0 up to base + wrap
    localparam int strobe_period = int'(period_send_2) + int'(wrap_offset) + 1;

    logic        link_up;
    logic        advance;
    logic        host_sync_model;   // host request registered while the link is up
    logic        in_reset_window;   // reset seen on the previous edge
    logic        cmd1_prev;
    logic        cmd2_prev;
    logic        saved_prev;
    logic        advance_prev;
    logic        blink_prev;
    logic [31:0] blink_gap;         // cycles since the last blink change
    int          high_run;          // advancing cycles with the strobe high
    int          rise_gap;          // advancing cycles since the last strobe
    logic        rise_seen;

    assign link_up = mac_inited & rx_ready;
    assign advance = link_up & host_sync_model;

    initial
    begin
        fail_count = 0;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("CHECK FAILED %s got 0x%h expected 0x%h at %0t ns", name, got, expected, $time);
        fail_count = fail_count + 1;
    endtask

    task automatic report_problem(input string what);
        $display("error at %0t ns: %s", $time, what);
        fail_count = fail_count + 1;
    endtask

    // ------------------------------------------------------------
    // reference state built from the port activity
    // ------------------------------------------------------------
    always_ff @(posedge clk_50_pll or posedge main_reset)
    begin
        if (main_reset)
        begin
            host_sync_model <= 1'b0;
            in_reset_window <= 1'b1;
            cmd1_prev       <= 1'b0;
            cmd2_prev       <= 1'b0;
            saved_prev      <= 1'b0;
            advance_prev    <= 1'b0;
            blink_prev      <= 1'b0;
            blink_gap       <= '0;
            high_run        <= 0;
            rise_gap        <= 0;
            rise_seen       <= 1'b0;
        end
        else
        begin
            if (link_up)
            begin
                host_sync_model <= host_send_cmd;   // held while the link is down
            end
            in_reset_window <= 1'b0;
            cmd1_prev       <= cmd_send_1;
            cmd2_prev       <= cmd_send_2;
            saved_prev      <= data_saved_2;
            advance_prev    <= advance;
            blink_prev      <= blink_led;
            blink_gap       <= (blink_led != blink_prev) ? 32'd1 : blink_gap + 32'd1;
            if (!cmd_send_1)
            begin
                high_run <= 0;
            end
            else if (advance)
            begin
                high_run <= high_run + 1;   // frozen cycles do not count
            end
            if (cmd_send_1 && !cmd1_prev)
            begin
                rise_seen <= 1'b1;
                rise_gap  <= advance ? 1 : 0;
            end
            else if (advance)
            begin
                rise_gap <= rise_gap + 1;
            end
        end
    end

    // ------------------------------------------------------------
    // reset state and indicators
    // ------------------------------------------------------------
    a_reset_cmd1 : assert property (@(posedge clk_50_pll) in_reset_window |-> !cmd_send_1)
        else report_mismatch("cmd_send_1", 32'($sampled(cmd_send_1)), 32'd0);
    a_reset_cmd2 : assert property (@(posedge clk_50_pll) in_reset_window |-> !cmd_send_2)
        else report_mismatch("cmd_send_2", 32'($sampled(cmd_send_2)), 32'd0);
    a_reset_blink : assert property (@(posedge clk_50_pll) in_reset_window |-> !blink_led)
        else report_mismatch("blink_led", 32'($sampled(blink_led)), 32'd0);
    a_reset_addr1 : assert property (@(posedge clk_50_pll)
        in_reset_window |-> start_ram_addr_1 == '0)
        else report_mismatch("start_ram_addr_1", 32'($sampled(start_ram_addr_1)), 32'd0);

    a_txflt_led : assert property (@(posedge clk_50_pll) sfp_txflt_led == mac_inited)
        else report_mismatch("sfp_txflt_led", 32'($sampled(sfp_txflt_led)),
                             32'($sampled(mac_inited)));
    a_rlos_led : assert property (@(posedge clk_50_pll) sfp_rlos_led == rx_ready)
        else report_mismatch("sfp_rlos_led", 32'($sampled(sfp_rlos_led)),
                             32'($sampled(rx_ready)));
    a_prsn_led : assert property (@(posedge clk_50_pll) sfp_prsn_led == rx_locked_to_ref)
        else report_mismatch("sfp_prsn_led", 32'($sampled(sfp_prsn_led)),
                             32'($sampled(rx_locked_to_ref)));

    a_blink_exact : assert property (@(posedge clk_50_pll) disable iff (main_reset)
        (blink_led != blink_prev) |-> blink_gap == blink_half_period)
        else report_problem($sformatf("blink_led toggled after %0d cycles instead of %0d",
                                      $sampled(blink_gap), blink_half_period));
    a_blink_due : assert property (@(posedge clk_50_pll) disable iff (main_reset)
        blink_gap <= blink_half_period)
        else report_problem("blink_led missed its toggle");

    // ------------------------------------------------------------
    // transmit channels
    // ------------------------------------------------------------
    a_strobe_max : assert property (@(posedge clk_50_pll) disable iff (main_reset)
        (cmd_send_1 && advance) |-> high_run < int'(strobe_len))
        else report_problem("cmd_send_1 stayed high past its strobe length");
    a_strobe_len : assert property (@(posedge clk_50_pll) disable iff (main_reset)
        (!cmd_send_1 && cmd1_prev && advance_prev) |-> high_run == int'(strobe_len))
        else report_problem($sformatf("cmd_send_1 strobe lasted %0d cycles instead of %0d",
                                      $sampled(high_run), strobe_len));
    a_strobe_period : assert property (@(posedge clk_50_pll) disable iff (main_reset)
        (cmd_send_1 && !cmd1_prev && rise_seen) |-> rise_gap == strobe_period)
        else report_problem($sformatf("cmd_send_1 strobes %0d cycles apart instead of %0d",
                                      $sampled(rise_gap), strobe_period));
    a_ch1_addr : assert property (@(posedge clk_50_pll) disable iff (main_reset)
        (cmd_send_1 || rise_seen) |-> start_ram_addr_1 == ch1_start_addr)
        else report_mismatch("start_ram_addr_1", 32'($sampled(start_ram_addr_1)),
                             32'(ch1_start_addr));

    a_ch2_host : assert property (@(posedge clk_50_pll) disable iff (main_reset)
        (advance && !cmd_send_2) |=> cmd_send_2)
        else report_mismatch("cmd_send_2", 32'($sampled(cmd_send_2)), 32'd1);
    a_ch2_addr : assert property (@(posedge clk_50_pll)
        start_ram_addr_2 == {{(ram_addr_w - host_addr_w){1'b0}}, host_start_addr})
        else report_mismatch("start_ram_addr_2", 32'($sampled(start_ram_addr_2)),
                             32'($sampled(host_start_addr)));
    a_ch2_relay : assert property (@(posedge clk_50_pll) disable iff (main_reset)
        (link_up && !host_sync_model) |=> cmd_send_2 == saved_prev)
        else report_mismatch("cmd_send_2", 32'($sampled(cmd_send_2)),
                             32'($sampled(saved_prev)));

    // both commands hold while the link is down
    a_gate_cmd1 : assert property (@(posedge clk_50_pll) disable iff (main_reset)
        !link_up |=> cmd_send_1 == cmd1_prev)
        else report_mismatch("cmd_send_1", 32'($sampled(cmd_send_1)), 32'($sampled(cmd1_prev)));
    a_gate_cmd2 : assert property (@(posedge clk_50_pll) disable iff (main_reset)
        !link_up |=> cmd_send_2 == cmd2_prev)
        else report_mismatch("cmd_send_2", 32'($sampled(cmd_send_2)), 32'($sampled(cmd2_prev)));

endmodule : tb_sfp_link_checks

/* design/sfp_link_ctrl_top.sv */
// top level of the sfp link control logic joining the transmit scheduler and the panel indicators
module sfp_link_ctrl_top
(
    input  logic                                        clk_50_pll,
    input  logic                                        main_reset,

    // ------------------------------------------------------------
    // link status
    // ------------------------------------------------------------
    input  logic                                        mac_inited,
    input  logic                                        rx_ready,
    input  logic                                        rx_locked_to_ref,

    // ------------------------------------------------------------
    // host and receive path
    // ------------------------------------------------------------
    input  logic                                        host_send_cmd,
    input  logic [sfp_link_ctrl_pkg::host_addr_w-1:0]   host_start_addr,
    input  logic                                        data_saved_2,

    // ------------------------------------------------------------
    // transmit commands
    // ------------------------------------------------------------
    output logic                                        cmd_send_1,
    output sfp_link_ctrl_pkg::ram_addr_t                start_ram_addr_1,
    output logic                                        cmd_send_2,
    output sfp_link_ctrl_pkg::ram_addr_t                start_ram_addr_2,

    // ------------------------------------------------------------
    // front panel
    // ------------------------------------------------------------
    output logic                                        blink_led,
    output logic                                        sfp_txflt_led,
    output logic                                        sfp_rlos_led,
    output logic                                        sfp_prsn_led
);

    // send pacing for both transmit channels
    tx_command_scheduler u_tx_command_scheduler
    (
        .clk_50_pll       (clk_50_pll),
        .main_reset       (main_reset),
        .mac_inited       (mac_inited),
        .rx_ready         (rx_ready),
        .host_send_cmd    (host_send_cmd),
        .host_start_addr  (host_start_addr),
        .data_saved_2     (data_saved_2),
        .cmd_send_1       (cmd_send_1),
        .start_ram_addr_1 (start_ram_addr_1),
        .cmd_send_2       (cmd_send_2),
        .start_ram_addr_2 (start_ram_addr_2)
    );

    // heartbeat and status LEDs
    led_status_driver u_led_status_driver
    (
        .clk_50_pll       (clk_50_pll),
        .main_reset       (main_reset),
        .mac_inited       (mac_inited),
        .rx_ready         (rx_ready),
        .rx_locked_to_ref (rx_locked_to_ref),
        .blink_led        (blink_led),
        .sfp_txflt_led    (sfp_txflt_led),
        .sfp_rlos_led     (sfp_rlos_led),
        .sfp_prsn_led     (sfp_prsn_led)
    );

endmodule : sfp_link_ctrl_top

/* design/led_status_driver.sv */
// front panel indicator logic with a heartbeat blink and link status mirroring
module led_status_driver
(
    input  logic clk_50_pll,
    input  logic main_reset,

    // link status sources
    input  logic mac_inited,
    input  logic rx_ready,
    input  logic rx_locked_to_ref,

    // front panel
    output logic blink_led,
    output logic sfp_txflt_led,
    output logic sfp_rlos_led,
    output logic sfp_prsn_led
);

    import sfp_link_ctrl_pkg::*;

    logic [31:0] blink_count;   // cycles since the last toggle

    // ------------------------------------------------------------
    // heartbeat divider
    // ------------------------------------------------------------
    always_ff @(posedge clk_50_pll or posedge main_reset)
    begin
        if (main_reset)
        begin
            blink_count <= '0;
            blink_led   <= 1'b0;
        end
        else if (blink_count == blink_half_period - 32'd1)
        begin
            blink_count <= '0;
            blink_led   <= ~blink_led;   // half period elapsed
        end
        else
        begin
            blink_count <= blink_count + 32'd1;
        end
    end

    // ------------------------------------------------------------
    // status mirrors
    // ------------------------------------------------------------
    assign sfp_txflt_led = mac_inited;         // MAC init done
    assign sfp_rlos_led  = rx_ready;           // receiver out of reset
    assign sfp_prsn_led  = rx_locked_to_ref;   // CDR locked to reference

    // a toggle is always followed by at least one steady cycle
    a_blink_steady : assert property (@(posedge clk_50_pll) disable iff (main_reset)
        $changed(blink_led) |=> $stable(blink_led));

endmodule : led_status_driver

/* design/tx_command_scheduler.sv */
// transmit command scheduler for both send channels, instantiated by the link control top level
module tx_command_scheduler
(
    input  logic                                        clk_50_pll,
    input  logic                                        main_reset,

    // link status from the MAC and transceiver reset logic
    input  logic                                        mac_inited,
    input  logic                                        rx_ready,

    // host send request and its start address
    input  logic                                        host_send_cmd,
    input  logic [sfp_link_ctrl_pkg::host_addr_w-1:0]   host_start_addr,

    // receive path notice for channel 2
    input  logic                                        data_saved_2,

    // transmit channel 1
    output logic                                        cmd_send_1,
    output sfp_link_ctrl_pkg::ram_addr_t                start_ram_addr_1,

    // transmit channel 2
    output logic                                        cmd_send_2,
    output sfp_link_ctrl_pkg::ram_addr_t                start_ram_addr_2
);

    import sfp_link_ctrl_pkg::*;

    logic         host_send_sync;   // registered host request
    logic         link_up;
    logic         advance;          // counter step enable
    send_count_t  send_count;

    relay_state_t relay_state;
    relay_state_t relay_next;

    assign link_up = mac_inited & rx_ready;
    assign advance = link_up & host_send_sync;

    // ------------------------------------------------------------
    // host request register
    // ------------------------------------------------------------

    // holds with the rest of the scheduler while the link is down
    always_ff @(posedge clk_50_pll or posedge main_reset)
    begin
        if (main_reset)
        begin
            host_send_sync <= 1'b0;
        end
        else if (link_up)
        begin
            host_send_sync <= host_send_cmd;
        end
    end

    // ------------------------------------------------------------
    // period counter and channel 1 strobe
    // ------------------------------------------------------------
    always_ff @(posedge clk_50_pll or posedge main_reset)
    begin
        if (main_reset)
        begin
            send_count       <= '0;
            cmd_send_1       <= 1'b0;
            start_ram_addr_1 <= '0;
        end
        else if (link_up)   // everything freezes while the link is down
        begin
            if (host_send_sync)
            begin
                send_count <= send_count + send_count_t'(1);
                if (send_count == period_send_1)
                begin
                    cmd_send_1       <= 1'b1;
                    start_ram_addr_1 <= ch1_start_addr;
                end
                else if (send_count == period_send_1 + strobe_len)
                begin
                    cmd_send_1 <= 1'b0;   // end of strobe
                end
                else if (send_count == period_send_2 + wrap_offset)
                begin
                    send_count <= '0;
                end
            end
            else
            begin
                cmd_send_1 <= 1'b0;   // request withdrawn so the counter holds
            end
        end
    end

    // ------------------------------------------------------------
    // channel 2 state machine
    // ------------------------------------------------------------
    always_ff @(posedge clk_50_pll or posedge main_reset)
    begin
        if (main_reset)
        begin
            relay_state <= relay_idle;
        end
        else
        begin
            relay_state <= relay_next;
        end
    end

    always_comb
    begin
        relay_next = relay_state;
        if (link_up)
        begin
            if (host_send_sync)
            begin
                // host mode gives only a one cycle gap per period
                case (relay_state)
                    relay_idle:
                    begin
                        relay_next = relay_sending;
                    end
                    relay_sending:
                    begin
                        if (send_count == period_send_2 + relay_release_offset)
                        begin
                            relay_next = relay_idle;
                        end
                    end
                    default:
                    begin
                        relay_next = relay_idle;
                    end
                endcase
            end
            else if (data_saved_2)
            begin
                relay_next = relay_sending;   // follow the receive path
            end
            else
            begin
                relay_next = relay_idle;
            end
        end
    end

    assign cmd_send_2 = (relay_state == relay_sending);

    // host address widened to a RAM address
    assign start_ram_addr_2 = ram_addr_t'(host_start_addr);

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------

    // after strobe_len advancing cycles high the strobe must drop
    a_strobe_len : assert property (@(posedge clk_50_pll) disable iff (main_reset)
        (cmd_send_1 && advance) [*strobe_len] |=> !cmd_send_1);

    a_count_range : assert property (@(posedge clk_50_pll) disable iff (main_reset)
        send_count <= period_send_2 + wrap_offset);

    // link down freezes channel 2
    a_ch2_frozen : assert property (@(posedge clk_50_pll) disable iff (main_reset)
        !link_up |=> $stable(cmd_send_2));

endmodule : tx_command_scheduler

/* design/sfp_link_ctrl_pkg.sv */
// timing constants and shared types for the sfp link control blocks, imported by each RTL module
package sfp_link_ctrl_pkg;

    // ------------------------------------------------------------
    // widths and data types
    // ------------------------------------------------------------
    localparam int send_count_w = 10;     // period counter
    localparam int ram_addr_w   = 25;     // packet RAM start address
    localparam int host_addr_w  = 6;      // address field from the host

    typedef logic [send_count_w-1:0] send_count_t;
    typedef logic [ram_addr_w-1:0]   ram_addr_t;

    // ------------------------------------------------------------
    // send timing (short test-build periods)
    // ------------------------------------------------------------

    // channel 1 strobe rises one edge after the counter hits this
    localparam send_count_t period_send_1 = send_count_t'(255);

    // base for the channel 2 release and the counter wrap
    localparam send_count_t period_send_2 = send_count_t'(511);

    localparam send_count_t strobe_len           = send_count_t'(3);   // strobe width in cycles
    localparam send_count_t wrap_offset          = send_count_t'(10);  // wrap at base + 10
    localparam send_count_t relay_release_offset = send_count_t'(3);   // host mode release point

    // first channel 1 transfer always starts at word 1
    localparam ram_addr_t ch1_start_addr = ram_addr_t'(1);

    // ------------------------------------------------------------
    // health indicator
    // ------------------------------------------------------------
    localparam logic [31:0] blink_half_period = 32'd25;   // cycles between toggles

    // ------------------------------------------------------------
    // channel 2 send state
    // ------------------------------------------------------------
    typedef enum logic
    {
        relay_idle    = 1'b0,   // no send requested
        relay_sending = 1'b1    // cmd_send_2 asserted
    } relay_state_t;

endpackage : sfp_link_ctrl_pkg
